// File: design/fpAddPkg.sv
// Single precision adder types
package fpAddPkg;

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX = 2 * EXP_BIAS + 1;
    localparam int MANT_WIDTH = 23;
    localparam int ALIGN_WIDTH = 32;
    localparam int BYPASS_SHIFT = 32;
    localparam logic [31:0] QNAN = 32'h7FC0_0000;
    localparam int PIPE_LATENCY = 3;

    typedef struct packed {
        logic                  sign;
        logic [7:0]            exponent;
        logic [MANT_WIDTH-1:0] fraction;
    } fpFields_t;

    // Raw word or IEEE fields
    typedef union packed {
        logic [31:0] bits;
        fpFields_t   fields;
    } fpWord_t;

    // Exponent here is the effective one
    typedef struct packed {
        logic                  sign;
        logic [7:0]            exponent;
        logic [MANT_WIDTH-1:0] fraction;
        logic                  isNaN;
        logic                  isInf;
        logic                  isZero;
        logic                  isSub;
    } fpOperand_t;

    typedef struct packed {
        logic                   valid;
        logic                   signA;
        logic                   signB;
        logic [7:0]             exponentOut;
        logic [ALIGN_WIDTH-1:0] alignedMantissaA;
        logic [ALIGN_WIDTH-1:0] alignedMantissaB;
        logic                   sticky;
        logic                   shiftOverflow;
        logic                   bypass;
        fpWord_t                bypassWord;
    } alignStage_t;

    typedef struct packed {
        logic                   valid;
        logic                   sign;
        logic signed [8:0]      exponent;
        logic [ALIGN_WIDTH:0]   sum;
        logic                   sticky;
        logic                   bypass;
        fpWord_t                bypassWord;
    } sumStage_t;

endpackage

// File: design/fpClassify.sv
// Operand unpack and classify
`timescale 1ns/1ps

module fpClassify import fpAddPkg::*;
(
    input  fpWord_t    operandA,
    input  fpWord_t    operandB,
    input  logic       opSub,
    output fpOperand_t opA,
    output fpOperand_t opB
);

    function automatic fpOperand_t classifyWord(input fpWord_t word, input logic flipSign);
        fpOperand_t op;
        logic expAllOnes;
        logic expZero;
        logic fracZero;
        expAllOnes = (word.fields.exponent == 8'(EXP_MAX));
        expZero = (word.fields.exponent == 8'd0);
        fracZero = (word.fields.fraction == '0);

        op.sign = word.fields.sign ^ flipSign;
        op.fraction = word.fields.fraction;
        op.isNaN = expAllOnes & ~fracZero;
        op.isInf = expAllOnes & fracZero;
        op.isZero = expZero & fracZero;
        op.isSub = expZero & ~fracZero;

        // Subnormals share the scale of exponent one
        if (op.isSub)
            op.exponent = 8'd1;
        else
            op.exponent = word.fields.exponent;
        return op;
    endfunction

    always_comb
    begin
        opA = classifyWord(operandA, 1'b0);
        // Subtraction flips B
        opB = classifyWord(operandB, opSub);
    end

endmodule

// File: design/fpAlign.sv
// Exponent compare and mantissa alignment
`timescale 1ns/1ps

module fpAlign import fpAddPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        inValid,
    input  fpOperand_t  opA,
    input  fpOperand_t  opB,
    output alignStage_t alignOut
);

    localparam int GUARD_BITS = ALIGN_WIDTH - MANT_WIDTH - 1;

    logic                   aLarger;
    logic [7:0]             expDiff;
    logic [ALIGN_WIDTH-1:0] mantA;
    logic [ALIGN_WIDTH-1:0] mantB;
    logic [ALIGN_WIDTH-1:0] largeMant;
    logic [ALIGN_WIDTH-1:0] smallMant;
    logic [ALIGN_WIDTH-1:0] shiftedSmall;
    logic [ALIGN_WIDTH-1:0] lostMask;
    logic                   sticky;
    logic                   shiftOverflow;
    logic                   special;
    logic                   farApart;
    fpWord_t                bypassWord;

    // Rebuild the IEEE word of an operand
    function automatic fpWord_t packWord(input fpOperand_t op);
        fpWord_t word;
        word.fields.sign = op.sign;
        word.fields.exponent = op.isSub ? 8'd0 : op.exponent;
        word.fields.fraction = op.fraction;
        return word;
    endfunction

    assign mantA = {~(opA.isSub | opA.isZero), opA.fraction, {GUARD_BITS{1'b0}}};
    assign mantB = {~(opB.isSub | opB.isZero), opB.fraction, {GUARD_BITS{1'b0}}};

    // Ties keep A as the reference exponent
    assign aLarger = (opA.exponent >= opB.exponent);
    assign expDiff = aLarger ? (opA.exponent - opB.exponent) : (opB.exponent - opA.exponent);
    assign largeMant = aLarger ? mantA : mantB;
    assign smallMant = aLarger ? mantB : mantA;
    assign shiftedSmall = smallMant >> expDiff;

    // Bits falling off the bottom of the window
    assign lostMask = (ALIGN_WIDTH'(1) << expDiff) - ALIGN_WIDTH'(1);
    assign sticky = |(smallMant & lostMask);
    // Fraction reaches past the guard positions
    assign shiftOverflow = (expDiff > 8'(GUARD_BITS));

    assign special = opA.isNaN | opB.isNaN | opA.isInf | opB.isInf | opA.isZero | opB.isZero;
    assign farApart = (expDiff >= 8'(BYPASS_SHIFT));

    always_comb
    begin
        if (opA.isNaN || opB.isNaN)
            bypassWord.bits = QNAN;
        else if (opA.isInf && opB.isInf)
            bypassWord = (opA.sign != opB.sign) ? fpWord_t'(QNAN) : packWord(opA);
        else if (opA.isInf)
            bypassWord = packWord(opA);
        else if (opB.isInf)
            bypassWord = packWord(opB);
        else if (opA.isZero && opB.isZero)
            bypassWord.bits = {opA.sign & opB.sign, 31'b0};
        else if (opA.isZero)
            bypassWord = packWord(opB);
        else if (opB.isZero)
            bypassWord = packWord(opA);
        else
            bypassWord = aLarger ? packWord(opA) : packWord(opB);
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            alignOut <= '0;
        else
        begin
            alignOut.valid <= inValid;
            alignOut.signA <= opA.sign;
            alignOut.signB <= opB.sign;
            alignOut.exponentOut <= aLarger ? opA.exponent : opB.exponent;
            alignOut.alignedMantissaA <= aLarger ? largeMant : shiftedSmall;
            alignOut.alignedMantissaB <= aLarger ? shiftedSmall : largeMant;
            alignOut.sticky <= sticky;
            alignOut.shiftOverflow <= shiftOverflow;
            alignOut.bypass <= special | farApart;
            alignOut.bypassWord <= bypassWord;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (alignOut.valid && !alignOut.bypass) |->
            (alignOut.exponentOut >= $past(opA.exponent) &&
             alignOut.exponentOut >= $past(opB.exponent)));

endmodule

// File: design/fpMantissaAdd.sv
// Aligned mantissa add and subtract
`timescale 1ns/1ps

module fpMantissaAdd import fpAddPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  alignStage_t alignIn,
    output sumStage_t   sumOut
);

    logic                   effSub;
    logic                   aGeB;
    logic                   borrow;
    logic                   resultSign;
    logic [ALIGN_WIDTH-1:0] largerMant;
    logic [ALIGN_WIDTH-1:0] smallerMant;
    logic [ALIGN_WIDTH-1:0] difference;
    logic [ALIGN_WIDTH:0]   total;

    always_comb
    begin
        effSub = alignIn.signA ^ alignIn.signB;
        aGeB = (alignIn.alignedMantissaA >= alignIn.alignedMantissaB);
        largerMant = aGeB ? alignIn.alignedMantissaA : alignIn.alignedMantissaB;
        smallerMant = aGeB ? alignIn.alignedMantissaB : alignIn.alignedMantissaA;

        // Lost low bits still reduce the difference by a fraction of an LSB
        borrow = effSub & alignIn.shiftOverflow & alignIn.sticky;
        difference = largerMant - smallerMant - ALIGN_WIDTH'(borrow);

        if (effSub)
        begin
            total = {1'b0, difference};
            // Exact cancellation is +0
            if (difference == '0)
                resultSign = 1'b0;
            else
                resultSign = aGeB ? alignIn.signA : alignIn.signB;
        end
        else
        begin
            total = {1'b0, alignIn.alignedMantissaA} + {1'b0, alignIn.alignedMantissaB};
            resultSign = alignIn.signA;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            sumOut <= '0;
        else
        begin
            sumOut.valid <= alignIn.valid;
            sumOut.sign <= resultSign;
            sumOut.exponent <= $signed({1'b0, alignIn.exponentOut});
            sumOut.sum <= total;
            sumOut.sticky <= alignIn.sticky;
            sumOut.bypass <= alignIn.bypass;
            sumOut.bypassWord <= alignIn.bypassWord;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (sumOut.valid && !sumOut.bypass && $past(effSub)) |->
            (sumOut.sum <= {1'b0, $past(largerMant)}));

endmodule

// File: design/fpNormalizeRound.sv
// Normalize and round to nearest even
`timescale 1ns/1ps

module fpNormalizeRound import fpAddPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  sumStage_t sumIn,
    output logic      outValid,
    output fpWord_t   result
);

    localparam int GUARD_BITS = ALIGN_WIDTH - MANT_WIDTH - 1;

    logic [5:0]             lz;
    logic [ALIGN_WIDTH-1:0] normMant;
    logic signed [9:0]      normExp;
    logic signed [9:0]      roundExp;
    logic                   stickyAll;
    logic                   guardBit;
    logic                   stickyBits;
    logic                   roundUp;
    logic [MANT_WIDTH+1:0]  rounded;
    logic [MANT_WIDTH-1:0]  finalFrac;
    fpWord_t                computed;

    function automatic logic [5:0] leadingZeros(input logic [ALIGN_WIDTH-1:0] value);
        logic [5:0] count;
        logic found;
        count = 6'(ALIGN_WIDTH);
        found = 1'b0;
        for (int i = ALIGN_WIDTH - 1; i >= 0; i--)
        begin
            if (!found && value[i])
            begin
                count = 6'(ALIGN_WIDTH - 1 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

    always_comb
    begin
        lz = leadingZeros(sumIn.sum[ALIGN_WIDTH-1:0]);
        stickyAll = sumIn.sticky;

        if (sumIn.sum[ALIGN_WIDTH])
        begin
            // Carry out shifts right by one
            normMant = sumIn.sum[ALIGN_WIDTH:1];
            stickyAll = sumIn.sticky | sumIn.sum[0];
            normExp = 10'(sumIn.exponent) + 10'sd1;
        end
        else
        begin
            normMant = sumIn.sum[ALIGN_WIDTH-1:0] << lz;
            normExp = 10'(sumIn.exponent) - $signed({4'b0, lz});
        end

        guardBit = normMant[GUARD_BITS-1];
        stickyBits = (|normMant[GUARD_BITS-2:0]) | stickyAll;
        roundUp = guardBit & (stickyBits | normMant[GUARD_BITS]);
        rounded = {1'b0, normMant[ALIGN_WIDTH-1:GUARD_BITS]} + (MANT_WIDTH + 2)'(roundUp);

        // Rounding carry renormalizes
        if (rounded[MANT_WIDTH+1])
        begin
            finalFrac = rounded[MANT_WIDTH:1];
            roundExp = normExp + 10'sd1;
        end
        else
        begin
            finalFrac = rounded[MANT_WIDTH-1:0];
            roundExp = normExp;
        end

        if (sumIn.sum == '0)
            computed.bits = {sumIn.sign, 31'b0};
        else if (roundExp >= EXP_MAX)
            computed.bits = {sumIn.sign, 8'hFF, {MANT_WIDTH{1'b0}}};
        else if (roundExp <= 0)
            computed.bits = {sumIn.sign, 31'b0};   // underflow flushes to zero
        else
        begin
            computed.fields.sign = sumIn.sign;
            computed.fields.exponent = roundExp[7:0];
            computed.fields.fraction = finalFrac;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
            result <= '0;
        end
        else
        begin
            outValid <= sumIn.valid;
            result <= sumIn.bypass ? sumIn.bypassWord : computed;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !$isunknown(outValid));

endmodule

// File: design/fpAdder.sv
// Pipelined float adder top
`timescale 1ns/1ps

module fpAdder import fpAddPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  logic    opSub,
    input  fpWord_t operandA,
    input  fpWord_t operandB,
    output logic    outValid,
    output fpWord_t result
);

    fpOperand_t  opA;
    fpOperand_t  opB;
    alignStage_t alignStage;
    sumStage_t   sumStage;

    fpClassify classify_i (
        .operandA (operandA),
        .operandB (operandB),
        .opSub    (opSub),
        .opA      (opA),
        .opB      (opB)
    );

    fpAlign align_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .alignOut (alignStage)
    );

    fpMantissaAdd add_i (
        .clk     (clk),
        .rstN    (rstN),
        .alignIn (alignStage),
        .sumOut  (sumStage)
    );

    fpNormalizeRound norm_i (
        .clk      (clk),
        .rstN     (rstN),
        .sumIn    (sumStage),
        .outValid (outValid),
        .result   (result)
    );

endmodule

// File: sim/fpAdderVectors.svh
// Adder test vectors
`ifndef FP_ADDER_VECTORS_SVH
`define FP_ADDER_VECTORS_SVH

typedef struct packed {
    logic        opSub;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
} vector_t;

localparam int NUM_VECTORS = 30;

// Columns opSub, operand A, operand B, expected result
localparam vector_t VECTORS [NUM_VECTORS] = '{
    {1'b0, 32'h3F80_0000, 32'h3F80_0000, 32'h4000_0000},
    {1'b1, 32'h3FC0_0000, 32'h3F00_0000, 32'h3F80_0000},
    {1'b1, 32'h4000_0000, 32'h3FC0_0000, 32'h3F00_0000},
    {1'b0, 32'h3DCC_CCCD, 32'h3E4C_CCCD, 32'h3E99_999A},
    // Ties to even and rounding carries
    {1'b0, 32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000},
    {1'b0, 32'h3F80_0001, 32'h3380_0000, 32'h3F80_0002},
    {1'b0, 32'h3FFF_FFFF, 32'h3380_0000, 32'h4000_0000},
    {1'b0, 32'h3F80_0000, 32'h3080_0000, 32'h3F80_0000},
    {1'b1, 32'h3F80_0000, 32'h3080_0000, 32'h3F80_0000},
    {1'b1, 32'h3F80_0000, 32'h3300_0000, 32'h3F80_0000},
    {1'b1, 32'h3F80_0000, 32'h3300_0001, 32'h3F7F_FFFF},
    // Cancellation
    {1'b1, 32'h3F80_0001, 32'h3F80_0000, 32'h3400_0000},
    {1'b1, 32'h3F80_0000, 32'h3F80_0000, 32'h0000_0000},
    {1'b0, 32'hBF80_0000, 32'h3F80_0000, 32'h0000_0000},
    {1'b0, 32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0000},
    {1'b0, 32'h7F80_0000, 32'h7F80_0000, 32'h7F80_0000},
    {1'b1, 32'h7F80_0000, 32'h7F80_0000, 32'h7FC0_0000},
    {1'b1, 32'h3F80_0000, 32'h7F80_0000, 32'hFF80_0000},
    {1'b0, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000},
    {1'b1, 32'h8000_0000, 32'h0000_0000, 32'h8000_0000},
    {1'b1, 32'h0000_0000, 32'h3F80_0000, 32'hBF80_0000},
    {1'b0, 32'h0000_0000, 32'h4049_0FDB, 32'h4049_0FDB},
    // Subnormals, flush to zero, overflow
    {1'b0, 32'h0000_0001, 32'h3F80_0000, 32'h3F80_0000},
    {1'b0, 32'h0000_0001, 32'h0000_0001, 32'h0000_0000},
    {1'b0, 32'h0040_0000, 32'h0040_0000, 32'h0080_0000},
    {1'b1, 32'h8080_0001, 32'h8080_0000, 32'h8000_0000},
    {1'b0, 32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000},
    {1'b0, 32'h7F7F_FFFF, 32'h7300_0000, 32'h7F80_0000},
    {1'b0, 32'h3F80_0000, 32'h2B80_0000, 32'h3F80_0000},
    {1'b1, 32'h2B80_0000, 32'h4700_0000, 32'hC700_0000}
};

`endif

// File: sim/fpAdderTb.sv
// Float adder testbench
`timescale 1ns/1ps

module fpAdderTb import fpAddPkg::*;
();

    `include "fpAdderVectors.svh"

    localparam int RESET_CYCLES = 3;
    localparam int MAX_GAP = 3;
    // Both passes at their slowest plus reset and drain
    localparam int TIMEOUT_CYCLES =
        2 * NUM_VECTORS * (MAX_GAP + 1) + PIPE_LATENCY + RESET_CYCLES + 10;

    logic    clk = 1'b0;
    logic    rstN;
    logic    inValid;
    logic    opSub;
    fpWord_t operandA;
    fpWord_t operandB;
    logic    outValid;
    fpWord_t result;

    int      cycleCount = 0;
    vector_t expectQ [$];
    int      strobeQ [$];
    vector_t doneRow;
    int      strobeCycle;

    fpAdder dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .opSub    (opSub),
        .operandA (operandA),
        .operandB (operandB),
        .outValid (outValid),
        .result   (result)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    task automatic stopRun();
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkWord(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s gave %h, expected %h",
                     $time, what, actual, expected);
            stopRun();
        end
    endtask

    task automatic driveRow(input vector_t row);
        @(posedge clk);
        inValid <= 1'b1;
        opSub <= row.opSub;
        operandA <= row.a;
        operandB <= row.b;
        expectQ.push_back(row);
    endtask

    task automatic idleCycles(input int count);
        repeat (count)
        begin
            @(posedge clk);
            inValid <= 1'b0;
        end
    endtask

    // Results and strobe times are checked off in order
    always @(negedge clk)
    begin
        if (outValid)
        begin
            if (expectQ.size() == 0)
            begin
                $display("error: outValid at %0t with no operation in flight", $time);
                stopRun();
            end
            else
            begin
                doneRow = expectQ.pop_front();
                strobeCycle = strobeQ.pop_front();
                checkWord(result.bits, doneRow.expected,
                          $sformatf("%h %s %h", doneRow.a, doneRow.opSub ? "-" : "+", doneRow.b));
                checkWord(32'(cycleCount - strobeCycle), 32'd3, "latency in cycles");
            end
        end
        // Strobe was driven on the last rising edge
        if (inValid && rstN)
            strobeQ.push_back(cycleCount);
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("error: results stopped arriving, watchdog expired after %0d cycles",
                 TIMEOUT_CYCLES);
        stopRun();
    end

    initial
    begin
        int order [NUM_VECTORS];
        int pick;
        int swap;
        void'($urandom(72));
        rstN = 1'b0;
        inValid = 1'b0;
        opSub = 1'b0;
        operandA = '0;
        operandB = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;

        // Table order back to back
        for (int i = 0; i < NUM_VECTORS; i++)
            driveRow(VECTORS[i]);
        idleCycles(2);

        // Shuffled order with idle gaps
        for (int i = 0; i < NUM_VECTORS; i++)
            order[i] = i;
        for (int i = NUM_VECTORS - 1; i > 0; i--)
        begin
            pick = $urandom_range(i, 0);
            swap = order[i];
            order[i] = order[pick];
            order[pick] = swap;
        end
        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            driveRow(VECTORS[order[i]]);
            idleCycles($urandom_range(MAX_GAP, 0));
        end
        idleCycles(1);

        // Wait for the last result and any stray outValid
        repeat (PIPE_LATENCY + 3) @(negedge clk);
        if (expectQ.size() != 0 || strobeQ.size() != 0)
        begin
            $display("error: %0d results never arrived", expectQ.size());
            stopRun();
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+sim
design/fpAddPkg.sv
design/fpClassify.sv
design/fpAlign.sv
design/fpMantissaAdd.sv
design/fpNormalizeRound.sv
design/fpAdder.sv
sim/fpAdderTb.sv

// File: Bender.yml
package:
  name: fp_adder

sources:
  - design/fpAddPkg.sv
  - design/fpClassify.sv
  - design/fpAlign.sv
  - design/fpMantissaAdd.sv
  - design/fpNormalizeRound.sv
  - design/fpAdder.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/fpAdderTb.sv
